// File: Makefile
# Verilator build for the BMP frame writer

VERILATOR  ?= verilator
FILELIST   ?= sources.f
TOP        ?= tbImageWrite
RTL_TOP    ?= imageWrite
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TEST OK
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

RTL_SRCS := source/bmpPkg.sv source/pixelCapture.sv source/bmpHeaderGen.sv \
            source/bmpByteSerializer.sv source/imageWrite.sv
ALL_SRCS := $(RTL_SRCS) source/bmp_config.svh tests/tbImageWrite.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+source $(RTL_SRCS) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(ALL_SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/bmpByteSerializer.sv
`timescale 1ns/1ps
`include "bmp_config.svh"

module bmpByteSerializer
    import bmpPkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        frameDone,
    input  byte_t       headerByte,
    input  byte_t       rdByte,
    input  logic        bmpAck,
    output streamIdx_t  headerIdx,
    output bufAddr_t    rdAddr,
    output byteStream_t bmpOut,
    output logic        busy
);

    localparam streamIdx_t HDR_LAST    = streamIdx_t'(`BMP_HEADER_BYTES - 1);
    localparam streamIdx_t STREAM_LAST = streamIdx_t'(`STREAM_BYTES - 1);
    localparam streamIdx_t HDR_LEN     = streamIdx_t'(`BMP_HEADER_BYTES);

    serState_t  state;
    streamIdx_t streamCnt;                              // Byte currently offered
    logic       inPixel;

    // Four-phase handshake, one REQ/REL pair per byte
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state     <= IDLE;
            streamCnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frameDone) begin
                        streamCnt <= '0;
                        state     <= HEADER_REQ;
                    end
                end
                HEADER_REQ: begin
                    if (bmpAck) begin
                        state <= HEADER_REL;
                    end
                end
                HEADER_REL: begin
                    // Wait for the sink to drop ack before moving on
                    if (!bmpAck) begin
                        streamCnt <= streamCnt + 1'b1;
                        if (streamCnt == HDR_LAST) begin
                            state <= PIXEL_REQ;
                        end else begin
                            state <= HEADER_REQ;
                        end
                    end
                end
                PIXEL_REQ: begin
                    if (bmpAck) begin
                        state <= PIXEL_REL;
                    end
                end
                PIXEL_REL: begin
                    if (!bmpAck) begin
                        if (streamCnt == STREAM_LAST) begin
                            streamCnt <= '0;
                            state     <= IDLE;              // Frame sent, re-arm
                        end else begin
                            streamCnt <= streamCnt + 1'b1;
                            state     <= PIXEL_REQ;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign inPixel = (state == PIXEL_REQ) || (state == PIXEL_REL);

    // Counter only changes on REL exit, so data holds through REQ
    assign headerIdx = streamCnt;
    assign rdAddr    = inPixel ? bufAddr_t'(streamCnt - HDR_LEN) : '0;

    assign bmpOut.req  = (state == HEADER_REQ) || (state == PIXEL_REQ);
    assign bmpOut.data = inPixel ? rdByte : headerByte;

    assign busy = (state != IDLE);

endmodule

// File: source/bmpHeaderGen.sv
`timescale 1ns/1ps
`include "bmp_config.svh"

module bmpHeaderGen
    import bmpPkg::*;
(
    input  streamIdx_t headerIdx,
    output byte_t      headerByte
);

    localparam logic [31:0] IMAGE_SIZE  = 32'(`IMAGE_BYTES);
    localparam logic [31:0] FILE_SIZE   = 32'(`STREAM_BYTES);
    localparam logic [31:0] PIX_OFFSET  = 32'(`BMP_HEADER_BYTES);
    localparam logic [31:0] DIB_SIZE    = 32'd40;
    localparam logic [31:0] IMG_W       = 32'(`IMG_WIDTH);
    localparam logic [31:0] IMG_H       = 32'(`IMG_HEIGHT);   // Positive, rows bottom-up
    localparam logic [15:0] PLANES      = 16'd1;
    localparam logic [15:0] BIT_DEPTH   = 16'd24;
    localparam logic [31:0] COMPRESSION = 32'd0;

    // Byte 0 sits at the LSB, so every field comes out little-endian
    localparam logic [8*`BMP_HEADER_BYTES-1:0] HEADER = {
        128'd0,                                         // Resolution and palette fields
        IMAGE_SIZE,                                     // Bytes 34..37
        COMPRESSION,                                    // Bytes 30..33
        BIT_DEPTH,                                      // Bytes 28..29
        PLANES,                                         // Bytes 26..27
        IMG_H,                                          // Bytes 22..25
        IMG_W,                                          // Bytes 18..21
        DIB_SIZE,                                       // Bytes 14..17
        PIX_OFFSET,                                     // Bytes 10..13
        32'd0,                                          // Reserved
        FILE_SIZE,                                      // Bytes 2..5
        8'h4D,                                          // 'M'
        8'h42                                           // 'B'
    };

    always_comb begin
        if (int'(headerIdx) < `BMP_HEADER_BYTES) begin
            headerByte = HEADER[8*int'(headerIdx) +: 8];
        end else begin
            headerByte = '0;
        end
    end

endmodule

// File: source/bmpPkg.sv
`include "bmp_config.svh"

package bmpPkg;

    typedef logic [7:0] byte_t;                         // Colour or stream byte

    typedef struct packed {
        byte_t red;
        byte_t green;
        byte_t blue;
    } rgbPixel_t;

    // Pixel 0 sits in the low bits of the beat
    typedef rgbPixel_t [`PIXELS_PER_BEAT-1:0] pixelBeat_t;

    typedef logic [$clog2(`BEATS_PER_ROW+1)-1:0] colIdx_t;   // Beat within a row
    typedef logic [$clog2(`IMG_HEIGHT+1)-1:0] rowIdx_t;      // Row within the frame

    typedef logic [$clog2(`IMAGE_BYTES)-1:0] bufAddr_t;      // Frame buffer byte address
    typedef logic [$clog2(`STREAM_BYTES)-1:0] streamIdx_t;   // Header plus image position

    // Byte port, data must be valid whenever req is high
    typedef struct packed {
        logic  req;
        byte_t data;
    } byteStream_t;

    typedef enum logic [2:0] {
        IDLE,
        HEADER_REQ,
        HEADER_REL,
        PIXEL_REQ,
        PIXEL_REL
    } serState_t;

endpackage

// File: source/bmp_config.svh
`ifndef BMP_CONFIG_SVH
`define BMP_CONFIG_SVH

// Image geometry
`define IMG_WIDTH 8
`define IMG_HEIGHT 4

// Pixels carried by one bus beat, IMG_WIDTH must be a multiple of it
`define PIXELS_PER_BEAT 2

// Fixed BMP header length (file header plus BITMAPINFOHEADER)
`define BMP_HEADER_BYTES 54

// Derived counts
`define BEATS_PER_ROW (`IMG_WIDTH / `PIXELS_PER_BEAT)
`define BEATS_PER_FRAME (`BEATS_PER_ROW * `IMG_HEIGHT)
`define ROW_BYTES (`IMG_WIDTH * 3)
`define BEAT_BYTES (`PIXELS_PER_BEAT * 3)
`define IMAGE_BYTES (`ROW_BYTES * `IMG_HEIGHT)
`define STREAM_BYTES (`BMP_HEADER_BYTES + `IMAGE_BYTES)

// No row padding, so a row must already be 4-byte aligned
`define ROW_ALIGN 4

`endif

// File: source/imageWrite.sv
`timescale 1ns/1ps

module imageWrite
    import bmpPkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        hsync,
    input  pixelBeat_t  beat,
    input  logic        bmpAck,
    output byteStream_t bmpOut,
    output logic        writeDone
);

    logic       busy;
    bufAddr_t   rdAddr;
    byte_t      rdByte;
    streamIdx_t headerIdx;
    byte_t      headerByte;

    pixelCapture uCapture (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hsync     (hsync),
        .beat      (beat),
        .busy      (busy),
        .rdAddr    (rdAddr),
        .rdByte    (rdByte),
        .frameDone (writeDone)                          // Done pulse also starts the stream
    );

    bmpHeaderGen uHeader (
        .headerIdx  (headerIdx),
        .headerByte (headerByte)
    );

    bmpByteSerializer uSerializer (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .frameDone  (writeDone),
        .headerByte (headerByte),
        .rdByte     (rdByte),
        .bmpAck     (bmpAck),
        .headerIdx  (headerIdx),
        .rdAddr     (rdAddr),
        .bmpOut     (bmpOut),
        .busy       (busy)
    );

endmodule

// File: source/pixelCapture.sv
`timescale 1ns/1ps
`include "bmp_config.svh"

module pixelCapture
    import bmpPkg::*;
(
    input  logic       HCLK,
    input  logic       HRESETn,
    input  logic       hsync,
    input  pixelBeat_t beat,
    input  logic       busy,
    input  bufAddr_t   rdAddr,
    output byte_t      rdByte,
    output logic       frameDone
);

    localparam colIdx_t COL_LAST = colIdx_t'(`BEATS_PER_ROW - 1);
    localparam rowIdx_t ROW_LAST = rowIdx_t'(`IMG_HEIGHT - 1);

    byte_t    frameMem [0:`IMAGE_BYTES-1];              // Bottom-up BGR image
    colIdx_t  col;
    rowIdx_t  row;
    logic     takeBeat;
    logic     lastBeat;
    bufAddr_t beatBase;

    // The done cycle is also blocked, the serializer is not busy yet there
    assign takeBeat = hsync && !busy && !frameDone;
    assign lastBeat = (col == COL_LAST) && (row == ROW_LAST);

    // BMP keeps the bottom row first in memory
    assign beatBase = bufAddr_t'((int'(ROW_LAST) - int'(row)) * `ROW_BYTES
                                 + int'(col) * `BEAT_BYTES);

    // Row and column counters
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            col <= '0;
            row <= '0;
        end else if (takeBeat) begin
            if (col == COL_LAST) begin
                col <= '0;
                if (row == ROW_LAST) begin
                    row <= '0;                          // Re-arm for next frame
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // One-cycle pulse after the edge that took the last beat
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            frameDone <= 1'b0;
        end else begin
            frameDone <= takeBeat && lastBeat;
        end
    end

    // Each pixel lands as blue, green, red
    always_ff @(posedge HCLK) begin
        if (takeBeat) begin
            for (int p = 0; p < `PIXELS_PER_BEAT; p++) begin
                frameMem[beatBase + bufAddr_t'(3 * p)]     <= beat[p].blue;
                frameMem[beatBase + bufAddr_t'(3 * p + 1)] <= beat[p].green;
                frameMem[beatBase + bufAddr_t'(3 * p + 2)] <= beat[p].red;
            end
        end
    end

    assign rdByte = frameMem[rdAddr];                   // Asynchronous read port

endmodule

// File: sources.f
+incdir+source
source/bmpPkg.sv
source/pixelCapture.sv
source/bmpHeaderGen.sv
source/bmpByteSerializer.sv
source/imageWrite.sv
tests/tbImageWrite.sv

// File: tests/image_cases.txt
// Beat words of frame 1 then frame 2, two beats per line, pixel 0 in the low 24 bits
// Last 9 words hold the expected BMP header, 6 bytes each, header byte 0 in the low 8 bits
// Frame 1 row 0
014181004080 034383024282
054585044484 074787064686
// Frame 1 row 1
115191105090 135393125292
155595145494 175797165696
// Frame 1 row 2
2161A12060A0 2363A32262A2
2565A52464A4 2767A72666A6
// Frame 1 row 3
3171B13070B0 3373B33272B2
3575B53474B4 3777B73676B6
// Frame 2 row 0
FEBE7EFFBF7F FCBC7CFDBD7D
FABA7AFBBB7B F8B878F9B979
// Frame 2 row 1
EEAE6EEFAF6F ECAC6CEDAD6D
EAAA6AEBAB6B E8A868E9A969
// Frame 2 row 2
DE9E5EDF9F5F DC9C5CDD9D5D
DA9A5ADB9B5B D89858D99959
// Frame 2 row 3
CE8E4ECF8F4F CC8C4CCD8D4D
CA8A4ACB8B4B C88848C98949
// Header for 8 by 4 pixels at 24 bits, file size 150, image size 96
000000964D42
003600000000
000000280000
000400000008
001800010000
006000000000
000000000000
000000000000
000000000000

// File: tests/tbImageWrite.sv
`timescale 1ns/1ps
`include "bmp_config.svh"

module tbImageWrite
    import bmpPkg::*;
();

    localparam int BEATS          = `BEATS_PER_FRAME;
    localparam int BEAT_BITS      = `PIXELS_PER_BEAT * 24;
    localparam int HDR_WORDS      = (`BMP_HEADER_BYTES + `BEAT_BYTES - 1) / `BEAT_BYTES;
    localparam int CASE_WORDS     = 2 * BEATS + HDR_WORDS;
    localparam int MAX_ACK_DELAY  = 3;
    // Each byte needs 4 cycles plus the sink's ack delay
    localparam int TIMEOUT_CYCLES = 2 * (BEATS + (4 + MAX_ACK_DELAY) * `STREAM_BYTES) + 200;

    logic        HCLK;
    logic        HRESETn;
    logic        hsync;
    pixelBeat_t  beat;
    logic        bmpAck = 1'b0;
    byteStream_t bmpOut;
    logic        writeDone;

    logic [BEAT_BITS-1:0] caseMem [0:CASE_WORDS-1];    // Beats of both frames, then header
    byte_t rxBytes [$];                                 // Every byte the sink accepted
    int    seed         = 32'h86a;
    int    cycle        = 0;
    int    rxCount      = 0;
    int    ackWait      = 0;
    int    expDoneCycle = -1;
    int    doneCount    = 0;
    int    doneErrors   = 0;
    int    protoErrors  = 0;
    int    streamBytes  = `STREAM_BYTES;                // Closed until writeDone
    logic  prevReq      = 1'b0;
    byte_t prevData     = '0;
    int    testsRun     = 0;
    int    testsFailed  = 0;
    int    errorTotal   = 0;

    imageWrite DUT (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hsync     (hsync),
        .beat      (beat),
        .bmpAck    (bmpAck),
        .bmpOut    (bmpOut),
        .writeDone (writeDone)
    );

    initial HCLK = 1'b0;
    always #10 HCLK = ~HCLK;

    // Cycle count and run limit
    always @(posedge HCLK) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout, the streams did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Four-phase sink, ack rises after a random wait
    always @(posedge HCLK) begin
        if (!HRESETn) begin
            bmpAck <= 1'b0;
        end else if (bmpAck) begin
            if (!bmpOut.req) begin
                bmpAck  <= 1'b0;
                ackWait <= int'($unsigned($random(seed)) % (MAX_ACK_DELAY + 1));
            end
        end else if (bmpOut.req) begin
            if (ackWait == 0) begin
                bmpAck  <= 1'b1;
                rxBytes.push_back(bmpOut.data);
                rxCount <= rxCount + 1;
            end else begin
                ackWait <= ackWait - 1;
            end
        end
    end

    // Done pulse timing and handshake rules
    always @(posedge HCLK) begin
        if (HRESETn) begin
            if (writeDone) begin
                doneCount++;
                streamBytes = 0;
                assert (cycle == expDoneCycle) else begin
                    $display("writeDone came at cycle %0d instead of cycle %0d",
                             cycle, expDoneCycle);
                    doneErrors++;
                end
            end
            if (bmpOut.req && !prevReq) begin
                assert (!bmpAck) else begin
                    $display("req rose while ack was still high");
                    protoErrors++;
                end
                assert (streamBytes < `STREAM_BYTES) else begin
                    $display("req rose with no byte of the frame left to send");
                    protoErrors++;
                end
                streamBytes++;
            end
            if (bmpOut.req && prevReq) begin
                assert (bmpOut.data == prevData) else begin
                    $display("error bmpOut.data: got 0x%02h, expected 0x%02h while req high",
                             bmpOut.data, prevData);
                    protoErrors++;
                end
            end
        end
        prevReq  = bmpOut.req;
        prevData = bmpOut.data;
    end

    task automatic finishTest(input string name, input int errs);
        testsRun++;
        errorTotal += errs;
        if (errs == 0) begin
            $display("test %s: pass", name);
        end else begin
            testsFailed++;
            $display("test %s: fail with %0d errors", name, errs);
        end
    endtask

    task automatic sendFrame(input int frame);
        for (int b = 0; b < BEATS; b++) begin
            @(posedge HCLK);
            hsync <= 1'b1;
            beat  <= caseMem[frame * BEATS + b];
            if (b == BEATS - 1) begin
                expDoneCycle = cycle + 2;               // Taken on the next edge, flag one later
            end else if ((b + 1) % `BEATS_PER_ROW == 0) begin
                @(posedge HCLK);
                hsync <= 1'b0;                          // Idle gap between rows
            end
        end
    endtask

    // Keeps hsync busy with noise until the sink has released the last byte
    task automatic streamJunk(input int framesSent);
        @(posedge HCLK);
        while (!(rxCount >= framesSent * `STREAM_BYTES && !bmpAck && !bmpOut.req)) begin
            hsync <= 1'b1;
            beat  <= {(BEAT_BITS / 8){8'(cycle) ^ 8'hA5}};
            @(posedge HCLK);
        end
        hsync <= 1'b0;
        repeat (MAX_ACK_DELAY + 5) @(posedge HCLK);     // A stray extra byte would land here
    endtask

    task automatic checkCount(input int frame);
        int errs;
        errs = 0;
        assert (rxBytes.size() == (frame + 1) * `STREAM_BYTES) else begin
            $display("frame %0d ends after %0d bytes in total, %0d expected", frame + 1,
                     rxBytes.size(), (frame + 1) * `STREAM_BYTES);
            errs++;
        end
        finishTest($sformatf("frame %0d byte count", frame + 1), errs);
    endtask

    task automatic checkHeader(input int frame);
        int    base;
        int    errs;
        byte_t exp;
        base = frame * `STREAM_BYTES;
        errs = 0;
        for (int i = 0; i < `BMP_HEADER_BYTES; i++) begin
            exp = caseMem[2 * BEATS + i / `BEAT_BYTES][8 * (i % `BEAT_BYTES) +: 8];
            assert (rxBytes[base + i] == exp) else begin
                $display("error bmpOut.data header byte %0d: got 0x%02h, expected 0x%02h",
                         i, rxBytes[base + i], exp);
                errs++;
            end
        end
        finishTest($sformatf("frame %0d header", frame + 1), errs);
    endtask

    task automatic checkPixels(input int frame);
        int                   base;
        int                   errs;
        int                   srcRow;
        int                   px;
        int                   comp;
        logic [BEAT_BITS-1:0] word;
        byte_t                exp;
        base = frame * `STREAM_BYTES + `BMP_HEADER_BYTES;
        errs = 0;
        for (int i = 0; i < `IMAGE_BYTES; i++) begin
            srcRow = `IMG_HEIGHT - 1 - i / `ROW_BYTES;  // Bottom row goes out first
            px     = (i % `ROW_BYTES) / 3;
            comp   = i % 3;                             // Blue is the low byte of a pixel
            word   = caseMem[frame * BEATS + srcRow * `BEATS_PER_ROW + px / `PIXELS_PER_BEAT];
            exp    = word[24 * (px % `PIXELS_PER_BEAT) + 8 * comp +: 8];
            assert (rxBytes[base + i] == exp) else begin
                $display("error bmpOut.data image byte %0d: got 0x%02h, expected 0x%02h",
                         i, rxBytes[base + i], exp);
                errs++;
            end
        end
        finishTest($sformatf("frame %0d pixels", frame + 1), errs);
    endtask

    initial begin
        HRESETn = 1'b0;
        hsync   = 1'b0;
        beat    = '0;
        caseMem[CASE_WORDS-1] = '1;                     // Marker, a complete file overwrites it
        $readmemh("tests/image_cases.txt", caseMem);
        assert (caseMem[CASE_WORDS-1] !== '1) else begin
            $display("tests/image_cases.txt is missing or too short");
            errorTotal++;
            testsFailed++;
        end
        repeat (16) @(posedge HCLK);
        HRESETn <= 1'b1;

        for (int f = 0; f < 2; f++) begin
            sendFrame(f);
            streamJunk(f + 1);
            checkCount(f);
            checkHeader(f);
            checkPixels(f);
        end

        repeat (8) @(posedge HCLK);                     // Room for a stray req to show
        assert (doneCount == 2) else begin
            $display("writeDone pulsed %0d times for 2 frames", doneCount);
            doneErrors++;
        end
        finishTest("done flag", doneErrors);
        finishTest("handshake", protoErrors);

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 testsRun, testsRun - testsFailed, testsFailed, errorTotal);
        if (testsFailed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
